// ==== atom_glue.f ====
+incdir+rtl
rtl/atom_glue_pkg.sv
rtl/clken_gen.sv
rtl/addr_decode.sv
rtl/pia_8255.sv
rtl/bank_regs.sv
rtl/cassette_tone.sv
rtl/atom_glue.sv
bench/atom_glue_sva.sv
bench/atom_glue_tb.sv

// ==== bench/atom_glue_sva.sv ====
`timescale 1ns/1ns

module atom_glue_sva
(
   input logic                   clk25,
   input logic                   reset,
   input logic                   cpu_clken,
   input atom_glue_pkg::nibble_t kbd_row,
   input logic                   an_g,
   input logic [2:0]             gm,
   input logic                   css,
   input logic                   audio_gate,
   input logic                   lock,
   input logic                   cas_tone
);

   // CPU cycles counted since the tone last moved
   logic [8:0] cycles_since;
   // Tone one clock ago
   logic       tone_q;

   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         cycles_since <= 9'd0;
         tone_q       <= 1'b0;
      end
      else
      begin
         tone_q <= cas_tone;
         // A flip starts a new half period
         if (cas_tone != tone_q)
            cycles_since <= cpu_clken ? 9'd1 : 9'd0;
         else if (cpu_clken)
            cycles_since <= cycles_since + 9'd1;
      end
   end

   // Enable is a single clock wide
   assert property (@(posedge clk25) disable iff (reset) cpu_clken |=> !cpu_clken)
      else $error("cpu_clken high on two consecutive clocks");

   // Port fields, lock and enable cleared by reset
   assert property (@(posedge clk25)
      reset |=> (kbd_row == 4'h0) && !an_g && (gm == 3'd0) && !css && !audio_gate
                && !lock && !cpu_clken)
      else $error("control outputs not low after reset");

   // Tone flips on exactly the 208th CPU cycle after the last flip
   assert property (@(posedge clk25) disable iff (reset)
      (cycles_since <= 9'd208) && (!$changed(cas_tone) || (cycles_since == 9'd208)))
      else $error("cas_tone did not hold for 208 CPU cycles between flips");

endmodule

// Bound into the top level where cas_tone is an internal net
bind atom_glue atom_glue_sva i_atom_glue_sva
(
   .clk25      (clk25),
   .reset      (reset),
   .cpu_clken  (cpu_clken),
   .kbd_row    (kbd_row),
   .an_g       (an_g),
   .gm         (gm),
   .css        (css),
   .audio_gate (audio_gate),
   .lock       (lock),
   .cas_tone   (cas_tone)
);

// ==== bench/atom_glue_tb.sv ====
`timescale 1ns/1ns

module atom_glue_tb;

   import atom_glue_pkg::*;

   localparam int MAX_ENTRIES = 64;
   localparam int CLKEN_LIMIT = 60;
   localparam int TONE_LIMIT  = 3000;

   // What an entry compares after its bus cycle
   typedef enum logic [2:0]
   {
      chk_none, chk_rdata, chk_region, chk_porta, chk_portc, chk_lock
   } check_e;

   logic clk25, reset, bus_rnw, shift_n, ctrl_n, rept_n, cas_in, fs_n;
   logic cpu_clken, rom_cs, an_g, css, audio_gate, cas_out, lock;
   turbo_e     turbo;
   addr_t      bus_addr;
   byte_t      bus_wdata, ext_rdata, bus_rdata;
   logic [5:0] key_cols;
   region_e    region;
   nibble_t    kbd_row;
   logic [2:0] gm;
   logic [31:0] seed;
   int n_errors, n_checks, n_entries;

   // Stimulus table with one column per array
   turbo_e  t_turbo  [MAX_ENTRIES];
   addr_t   t_addr   [MAX_ENTRIES];
   byte_t   t_wdata  [MAX_ENTRIES];
   logic    t_rnw    [MAX_ENTRIES];
   check_e  t_check  [MAX_ENTRIES];
   byte_t   t_byte   [MAX_ENTRIES];
   region_e t_region [MAX_ENTRIES];
   logic    t_bit    [MAX_ENTRIES];

   atom_glue i_atom_glue
   (
      .clk25 (clk25), .reset (reset), .turbo (turbo),
      .bus_addr (bus_addr), .bus_wdata (bus_wdata), .bus_rnw (bus_rnw),
      .ext_rdata (ext_rdata), .key_cols (key_cols), .shift_n (shift_n),
      .ctrl_n (ctrl_n), .rept_n (rept_n), .cas_in (cas_in), .fs_n (fs_n),
      .cpu_clken (cpu_clken), .bus_rdata (bus_rdata), .region (region),
      .rom_cs (rom_cs), .kbd_row (kbd_row), .an_g (an_g), .gm (gm),
      .css (css), .audio_gate (audio_gate), .cas_out (cas_out), .lock (lock)
   );

   // 8 ns clock
   initial
   begin
      clk25 = 1'b0;
      forever #4 clk25 = ~clk25;
   end

   function automatic logic [31:0] next_random(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // ======================================================================
   // Compare tasks
   // ======================================================================

   task automatic check_byte(input string name, input byte_t got, input byte_t exp);
      n_checks++;
      if (got !== exp)
      begin
         n_errors++;
         $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_region(input string name, input region_e got, input region_e exp);
      n_checks++;
      if (got !== exp)
      begin
         n_errors++;
         $display("FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      n_checks++;
      if (got !== exp)
      begin
         n_errors++;
         $display("FAILED at %0t ns: %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      n_checks++;
      if (got != exp)
      begin
         n_errors++;
         $display("FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
      end
   endtask

   // ======================================================================
   // Bus cycle
   // ======================================================================

   // Called at a falling edge and returns at one
   task automatic wait_clken;
      int n;
      n = 0;
      while (!cpu_clken && n < CLKEN_LIMIT)
      begin
         @(negedge clk25);
         n++;
      end
      if (!cpu_clken)
      begin
         $display("Timeout: no cpu_clken within %0d clocks", CLKEN_LIMIT);
         $display("Simulation failed");
         $finish;
      end
   endtask

   // Hold the bus through the next enable edge
   task automatic bus_cycle(input turbo_e speed, input addr_t addr, input byte_t data,
                            input logic rnw);
      @(negedge clk25);
      turbo     = speed;
      bus_addr  = addr;
      bus_wdata = data;
      bus_rnw   = rnw;
      wait_clken();
      @(negedge clk25);
      bus_rnw = 1'b1;
   endtask

   task automatic add_entry(input turbo_e speed, input addr_t addr, input byte_t data,
                            input logic rnw, input check_e chk, input byte_t eb,
                            input region_e er, input logic ebit);
      t_turbo[n_entries]  = speed;
      t_addr[n_entries]   = addr;
      t_wdata[n_entries]  = data;
      t_rnw[n_entries]    = rnw;
      t_check[n_entries]  = chk;
      t_byte[n_entries]   = eb;
      t_region[n_entries] = er;
      t_bit[n_entries]    = ebit;
      n_entries++;
   endtask

   // ======================================================================
   // Tests
   // ======================================================================

   // 100 clocks are four 25-clock frames
   task automatic test_clken(input turbo_e speed, input int per_frame);
      int pulses;
      int err_before;
      err_before = n_errors;
      @(negedge clk25);
      turbo = speed;
      // Let the registered enable settle on the new pattern
      repeat (30) @(negedge clk25);
      pulses = 0;
      repeat (100)
      begin
         @(negedge clk25);
         if (cpu_clken)
            pulses++;
      end
      check_count("cpu_clken pulses", pulses, 4 * per_frame);
      $display("clock enable turbo %0d: %s", speed, (n_errors == err_before) ? "ok" : "error");
   endtask

   // Sample before advancing so the last pulse before the flip is counted
   task automatic count_half_period(output int pulses);
      logic start;
      int   n;
      start  = cas_out;
      pulses = 0;
      n      = 0;
      while (cas_out === start && n < TONE_LIMIT)
      begin
         if (cpu_clken)
            pulses++;
         @(negedge clk25);
         n++;
      end
      if (cas_out === start)
      begin
         $display("Timeout: cas_out did not change within %0d clocks", TONE_LIMIT);
         $display("Simulation failed");
         $finish;
      end
   endtask

   task automatic test_cassette;
      int   pulses;
      int   err_before;
      logic seen;
      err_before = n_errors;
      // Gate open so the output follows the inverted tone
      bus_cycle(turbo_4mhz, 16'hb002, 8'h03, 1'b0);
      count_half_period(pulses);
      count_half_period(pulses);
      check_count("cas_out half period", pulses, 208);
      count_half_period(pulses);
      check_count("cas_out half period", pulses, 208);
      // Bit 0 low forces the output high across a tone flip
      bus_cycle(turbo_4mhz, 16'hb002, 8'h02, 1'b0);
      seen = 1'b1;
      repeat (1500)
      begin
         @(negedge clk25);
         if (cas_out !== 1'b1)
            seen = cas_out;
      end
      check_bit("cas_out", seen, 1'b1);
      $display("cassette tone: %s", (n_errors == err_before) ? "ok" : "error");
   endtask

   task automatic build_table;
      byte_t port_b;
      port_b = {shift_n, ctrl_n, key_cols};
      // Decode across the map with the bank latch still zero
      add_entry(turbo_1mhz, 16'h0000, 8'h00, 1'b1, chk_region, 8'h00, reg_ram, 1'b0);
      add_entry(turbo_1mhz, 16'h1234, 8'h00, 1'b1, chk_rdata, ext_rdata, reg_ram, 1'b0);
      add_entry(turbo_2mhz, 16'h8000, 8'h00, 1'b1, chk_region, 8'h00, reg_vid, 1'b0);
      add_entry(turbo_2mhz, 16'h97ff, 8'h00, 1'b1, chk_region, 8'h00, reg_vid, 1'b0);
      add_entry(turbo_2mhz, 16'h9800, 8'h00, 1'b1, chk_region, 8'h00, reg_ram, 1'b0);
      add_entry(turbo_4mhz, 16'ha000, 8'h00, 1'b1, chk_region, 8'h00, reg_rom, 1'b1);
      add_entry(turbo_4mhz, 16'hb000, 8'h00, 1'b1, chk_region, 8'h00, reg_pia, 1'b0);
      add_entry(turbo_4mhz, 16'hb40f, 8'h00, 1'b1, chk_region, 8'h00, reg_pl8, 1'b0);
      add_entry(turbo_4mhz, 16'hb400, 8'h00, 1'b1, chk_rdata, 8'h00, reg_pl8, 1'b0);
      add_entry(turbo_4mhz, 16'hb800, 8'h00, 1'b1, chk_region, 8'h00, reg_via, 1'b0);
      add_entry(turbo_4mhz, 16'hbc00, 8'h00, 1'b1, chk_region, 8'h00, reg_spi, 1'b0);
      add_entry(turbo_4mhz, 16'hbd20, 8'h00, 1'b1, chk_region, 8'h00, reg_sid, 1'b0);
      add_entry(turbo_4mhz, 16'hbfff, 8'h00, 1'b1, chk_region, 8'h00, reg_latch, 1'b0);
      add_entry(turbo_4mhz, 16'hc000, 8'h00, 1'b1, chk_region, 8'h00, reg_rom, 1'b1);
      add_entry(turbo_4mhz, 16'hffff, 8'h00, 1'b1, chk_region, 8'h00, reg_rom, 1'b1);
      // PIA port A, port C nibble and bit set/reset
      add_entry(turbo_4mhz, 16'hb000, 8'ha5, 1'b0, chk_none, 8'h00, reg_pia, 1'b0);
      add_entry(turbo_4mhz, 16'hb000, 8'h00, 1'b1, chk_porta, 8'ha5, reg_pia, 1'b0);
      add_entry(turbo_4mhz, 16'hb000, 8'h00, 1'b1, chk_rdata, 8'ha5, reg_pia, 1'b0);
      add_entry(turbo_4mhz, 16'hb002, 8'h0c, 1'b0, chk_portc, 8'h0c, reg_pia, 1'b0);
      add_entry(turbo_4mhz, 16'hb003, 8'h04, 1'b0, chk_portc, 8'h08, reg_pia, 1'b0);
      add_entry(turbo_4mhz, 16'hb003, 8'h05, 1'b0, chk_portc, 8'h0c, reg_pia, 1'b0);
      add_entry(turbo_4mhz, 16'hb003, 8'h06, 1'b0, chk_portc, 8'h04, reg_pia, 1'b0);
      // Mode word with bit 7 set would otherwise set bit 3
      add_entry(turbo_4mhz, 16'hb003, 8'h87, 1'b0, chk_portc, 8'h04, reg_pia, 1'b0);
      add_entry(turbo_4mhz, 16'hb001, 8'h00, 1'b1, chk_rdata, port_b, reg_pia, 1'b0);
      add_entry(turbo_4mhz, 16'hb003, 8'h00, 1'b1, chk_rdata, 8'h00, reg_pia, 1'b0);
      // Bank latch where bank 7 maps RAM at A000
      add_entry(turbo_4mhz, 16'hbfff, 8'h5a, 1'b0, chk_none, 8'h00, reg_latch, 1'b0);
      add_entry(turbo_4mhz, 16'hbfff, 8'h00, 1'b1, chk_rdata, 8'h5a, reg_latch, 1'b0);
      add_entry(turbo_4mhz, 16'ha000, 8'h00, 1'b1, chk_region, 8'h00, reg_rom, 1'b1);
      add_entry(turbo_4mhz, 16'hbfff, 8'h07, 1'b0, chk_none, 8'h00, reg_latch, 1'b0);
      add_entry(turbo_4mhz, 16'ha000, 8'h00, 1'b1, chk_region, 8'h00, reg_ram, 1'b0);
      add_entry(turbo_4mhz, 16'ha000, 8'h00, 1'b1, chk_rdata, ext_rdata, reg_ram, 1'b0);
      add_entry(turbo_4mhz, 16'hbfff, 8'h0b, 1'b0, chk_none, 8'h00, reg_latch, 1'b0);
      add_entry(turbo_4mhz, 16'ha000, 8'h00, 1'b1, chk_region, 8'h00, reg_rom, 1'b1);
      // Lock flag that the neighbour byte must not touch
      add_entry(turbo_2mhz, 16'h00e7, 8'h20, 1'b0, chk_lock, 8'h00, reg_ram, 1'b1);
      add_entry(turbo_2mhz, 16'h00e6, 8'h00, 1'b0, chk_lock, 8'h00, reg_ram, 1'b1);
      add_entry(turbo_2mhz, 16'h00e7, 8'hdf, 1'b0, chk_lock, 8'h00, reg_ram, 1'b0);
   endtask

   task automatic run_table;
      int err_before;
      for (int i = 0; i < n_entries; i++)
      begin
         err_before = n_errors;
         bus_cycle(t_turbo[i], t_addr[i], t_wdata[i], t_rnw[i]);
         case (t_check[i])
            chk_rdata:
               check_byte("bus_rdata", bus_rdata, t_byte[i]);
            chk_region:
            begin
               check_region("region", region, t_region[i]);
               check_bit("rom_cs", rom_cs, t_bit[i]);
            end
            chk_porta:
               check_byte("gm an_g kbd_row", byte_t'({gm, an_g, kbd_row}), t_byte[i]);
            chk_portc:
            begin
               check_bit("css", css, t_byte[i][3]);
               check_bit("audio_gate", audio_gate, t_byte[i][2]);
            end
            chk_lock:
               check_bit("lock", lock, t_bit[i]);
            default:
               ;
         endcase
         $display("entry %0d %s %h: %s", i, t_rnw[i] ? "read " : "write", t_addr[i],
                  (n_errors == err_before) ? "ok" : "error");
      end
   endtask

   // ======================================================================
   // Main sequence
   // ======================================================================

   initial
   begin
      seed      = 32'hbe37_9e08;
      n_errors  = 0;
      n_checks  = 0;
      n_entries = 0;
      reset     = 1'b1;
      turbo     = turbo_4mhz;
      bus_addr  = 16'h0000;
      bus_wdata = 8'h00;
      bus_rnw   = 1'b1;
      seed      = next_random(seed);
      ext_rdata = seed[7:0];
      seed      = next_random(seed);
      key_cols  = seed[5:0];
      shift_n   = 1'b1;
      ctrl_n    = 1'b0;
      rept_n    = 1'b1;
      cas_in    = 1'b0;
      fs_n      = 1'b1;
      repeat (4) @(posedge clk25);
      @(negedge clk25);
      reset = 1'b0;

      test_clken(turbo_1mhz, 1);
      test_clken(turbo_2mhz, 2);
      test_clken(turbo_4mhz, 4);
      build_table();
      run_table();
      test_cassette();

      $display("checks %0d, errors %0d", n_checks, n_errors);
      if (n_errors == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

// ==== rtl/addr_decode.sv ====
`timescale 1ns/1ns

`include "atom_glue_params.svh"

module addr_decode
(
   input  atom_glue_pkg::addr_t   bus_addr,
   input  atom_glue_pkg::byte_t   rom_bank,
   input  atom_glue_pkg::byte_t   pia_rdata,
   input  atom_glue_pkg::byte_t   latch_rdata,
   input  atom_glue_pkg::byte_t   ext_rdata,
   output atom_glue_pkg::region_e region,
   output logic                   rom_cs,
   output atom_glue_pkg::byte_t   bus_rdata
);

   import atom_glue_pkg::*;

   // ======================================================================
   // Memory map
   // ======================================================================
   // 0000-7FFF RAM
   // 8000-97FF video RAM, 9800-9FFF RAM
   // A000-AFFF banked ROM, or RAM when bank bits 2..0 are all set
   // B000 PIA, B400 empty, B800 VIA, BC00 SPI, BDxx SID
   // BFFF bank latch
   // C000-FFFF ROM

   logic vid_hit;
   logic a000_hit;
   logic a000_ram;

   assign vid_hit  = (bus_addr[15:12] == 4'h8) | (bus_addr[15:11] == 5'b10010);
   assign a000_hit = (bus_addr[15:12] == 4'ha);
   // Bank 7 maps RAM into the A block
   assign a000_ram = (rom_bank[2:0] == 3'b111);

   always_comb
   begin
      region = reg_ram;
      if (vid_hit)
         region = reg_vid;
      else if (bus_addr[15:14] == 2'b11)
         region = reg_rom;
      else if (a000_hit)
         region = a000_ram ? reg_ram : reg_rom;
      else if (bus_addr == `ATOM_ROM_LATCH_ADDR)
         region = reg_latch;
      else if (bus_addr[15:4] == `ATOM_PIA_PAGE)
         region = reg_pia;
      else if (bus_addr[15:4] == `ATOM_PL8_PAGE)
         region = reg_pl8;
      else if (bus_addr[15:4] == `ATOM_VIA_PAGE)
         region = reg_via;
      else if (bus_addr[15:4] == `ATOM_SPI_PAGE)
         region = reg_spi;
      else if (bus_addr[15:8] == `ATOM_SID_PAGE)
         region = reg_sid;
   end

   // Same rule as the region, C000 up or unbanked A block
   assign rom_cs = (region == reg_rom);

   // ======================================================================
   // Read data multiplexer
   // ======================================================================

   always_comb
   begin
      case (region)
         reg_pia:   bus_rdata = pia_rdata;
         // Nothing fitted in the B400 block
         reg_pl8:   bus_rdata = 8'h00;
         reg_latch: bus_rdata = latch_rdata;
         // RAM, video, ROM and the other devices sit outside
         default:   bus_rdata = ext_rdata;
      endcase
   end

endmodule

// ==== rtl/atom_glue.sv ====
`timescale 1ns/1ns

module atom_glue
(
   input  logic                   clk25,
   input  logic                   reset,
   input  atom_glue_pkg::turbo_e  turbo,
   // Registered processor bus
   input  atom_glue_pkg::addr_t   bus_addr,
   input  atom_glue_pkg::byte_t   bus_wdata,
   input  logic                   bus_rnw,
   input  atom_glue_pkg::byte_t   ext_rdata,
   // Keyboard and status inputs
   input  logic [5:0]             key_cols,
   input  logic                   shift_n,
   input  logic                   ctrl_n,
   input  logic                   rept_n,
   input  logic                   cas_in,
   input  logic                   fs_n,
   output logic                   cpu_clken,
   output atom_glue_pkg::byte_t   bus_rdata,
   output atom_glue_pkg::region_e region,
   output logic                   rom_cs,
   // Port A and port C fields
   output atom_glue_pkg::nibble_t kbd_row,
   output logic                   an_g,
   output logic [2:0]             gm,
   output logic                   css,
   output logic                   audio_gate,
   output logic                   cas_out,
   output logic                   lock
);

   import atom_glue_pkg::*;

   byte_t   port_a;
   nibble_t port_c_lo;
   byte_t   pia_rdata;
   byte_t   rom_bank;
   logic    cas_tone;

   // ======================================================================
   // Cycle enable
   // ======================================================================

   clken_gen i_clken_gen
   (
      .clk25     (clk25),
      .reset     (reset),
      .turbo     (turbo),
      .cpu_clken (cpu_clken)
   );

   // ======================================================================
   // Decode and read path
   // ======================================================================

   // Latch reads back what was written
   addr_decode i_addr_decode
   (
      .bus_addr    (bus_addr),
      .rom_bank    (rom_bank),
      .pia_rdata   (pia_rdata),
      .latch_rdata (rom_bank),
      .ext_rdata   (ext_rdata),
      .region      (region),
      .rom_cs      (rom_cs),
      .bus_rdata   (bus_rdata)
   );

   // ======================================================================
   // Registers
   // ======================================================================

   pia_8255 i_pia_8255
   (
      .clk25     (clk25),
      .reset     (reset),
      .cpu_clken (cpu_clken),
      .bus_addr  (bus_addr),
      .bus_wdata (bus_wdata),
      .bus_rnw   (bus_rnw),
      .pia_sel   (region == reg_pia),
      .key_cols  (key_cols),
      .shift_n   (shift_n),
      .ctrl_n    (ctrl_n),
      .rept_n    (rept_n),
      .cas_in    (cas_in),
      .fs_n      (fs_n),
      .cas_tone  (cas_tone),
      .port_a    (port_a),
      .port_c_lo (port_c_lo),
      .pia_rdata (pia_rdata)
   );

   bank_regs i_bank_regs
   (
      .clk25     (clk25),
      .reset     (reset),
      .cpu_clken (cpu_clken),
      .bus_addr  (bus_addr),
      .bus_wdata (bus_wdata),
      .bus_rnw   (bus_rnw),
      .latch_sel (region == reg_latch),
      .rom_bank  (rom_bank),
      .lock      (lock)
   );

   // Port C bits 1 and 0 gate the tone
   cassette_tone i_cassette_tone
   (
      .clk25     (clk25),
      .reset     (reset),
      .cpu_clken (cpu_clken),
      .cas_ctrl  (port_c_lo[1:0]),
      .cas_tone  (cas_tone),
      .cas_out   (cas_out)
   );

   // Keyboard row and video mode from port A
   assign kbd_row    = port_a[3:0];
   assign an_g       = port_a[4];
   assign gm         = port_a[7:5];

   // Colour set and speaker enable from port C
   assign css        = port_c_lo[3];
   assign audio_gate = port_c_lo[2];

endmodule

// ==== rtl/atom_glue_params.svh ====
`ifndef ATOM_GLUE_PARAMS_SVH
`define ATOM_GLUE_PARAMS_SVH

// ======================================================================
// Divider counts
// ======================================================================

// 25 MHz down to the 1 MHz frame of 25 clocks
`define ATOM_CLKDIV_LAST 24

// 208 CPU cycles per tone half period
`define ATOM_CAS_DIV_LAST 207

// ======================================================================
// Special locations
// ======================================================================

// ROM bank latch, write and read back
`define ATOM_ROM_LATCH_ADDR 16'hbfff

// Zero-page byte holding the lock flag
`define ATOM_LOCK_ADDR 16'h00e7
`define ATOM_LOCK_BIT 5

// ======================================================================
// Device blocks in the B000 page
// ======================================================================

// 16-byte blocks, matched on address bits 15 to 4
`define ATOM_PIA_PAGE 12'hb00
`define ATOM_PL8_PAGE 12'hb40
`define ATOM_VIA_PAGE 12'hb80
`define ATOM_SPI_PAGE 12'hbc0

// 256-byte SID block, matched on bits 15 to 8
`define ATOM_SID_PAGE 8'hbd

`endif

// ==== rtl/atom_glue_pkg.sv ====
package atom_glue_pkg;

   // CPU address bus
   typedef logic [15:0] addr_t;

   // Data bus byte
   typedef logic [7:0] byte_t;

   // Port C output latch, keyboard row
   typedef logic [3:0] nibble_t;

   // CPU speed select
   typedef enum logic [1:0]
   {
      turbo_1mhz = 2'd0,
      turbo_2mhz = 2'd1,
      turbo_4mhz = 2'd2
   } turbo_e;

   // Decoded memory-map region
   typedef enum logic [3:0]
   {
      reg_ram   = 4'd0,
      reg_vid   = 4'd1,
      reg_pia   = 4'd2,
      reg_pl8   = 4'd3,
      reg_via   = 4'd4,
      reg_spi   = 4'd5,
      reg_sid   = 4'd6,
      reg_rom   = 4'd7,
      reg_latch = 4'd8
   } region_e;

endpackage

// ==== rtl/bank_regs.sv ====
`timescale 1ns/1ns

`include "atom_glue_params.svh"

module bank_regs
(
   input  logic                 clk25,
   input  logic                 reset,
   input  logic                 cpu_clken,
   input  atom_glue_pkg::addr_t bus_addr,
   input  atom_glue_pkg::byte_t bus_wdata,
   input  logic                 bus_rnw,
   input  logic                 latch_sel,
   output atom_glue_pkg::byte_t rom_bank,
   output logic                 lock
);

   // Any CPU write cycle
   logic wr_cycle;

   assign wr_cycle = cpu_clken & ~bus_rnw;

   // ROM bank latch at BFFF
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
         rom_bank <= 8'h00;
      else if (wr_cycle && latch_sel)
         rom_bank <= bus_wdata;
   end

   // Lock flag snooped from writes to zero page E7
   // The RAM still takes the byte as well
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
         lock <= 1'b0;
      else if (wr_cycle && (bus_addr == `ATOM_LOCK_ADDR))
         lock <= bus_wdata[`ATOM_LOCK_BIT];
   end

endmodule

// ==== rtl/cassette_tone.sv ====
`timescale 1ns/1ns

`include "atom_glue_params.svh"

module cassette_tone
(
   input  logic       clk25,
   input  logic       reset,
   input  logic       cpu_clken,
   input  logic [1:0] cas_ctrl,
   output logic       cas_tone,
   output logic       cas_out
);

   // CPU cycle count within a half period
   logic [7:0] cas_div;

   // Tone, 208 cycles high then 208 low
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         cas_div  <= 8'd0;
         cas_tone <= 1'b0;
      end
      else if (cpu_clken)
      begin
         if (cas_div == 8'(`ATOM_CAS_DIV_LAST))
         begin
            cas_div  <= 8'd0;
            cas_tone <= ~cas_tone;
         end
         else
            cas_div <= cas_div + 8'd1;
      end
   end

   // Output gate, two NANDs and an inverter on the board
   // Bit 0 low forces high, bit 1 passes the inverted tone
   assign cas_out = ~cas_ctrl[0] | (cas_ctrl[1] & ~cas_tone);

endmodule

// ==== rtl/clken_gen.sv ====
`timescale 1ns/1ns

`include "atom_glue_params.svh"

module clken_gen
(
   input  logic                  clk25,
   input  logic                  reset,
   input  atom_glue_pkg::turbo_e turbo,
   output logic                  cpu_clken
);

   import atom_glue_pkg::*;

   // Position within the 25-clock frame
   logic [4:0] div_cnt;
   logic       clken_next;

   // Enable pattern per speed
   // Upper half of the frame (count 16 and up) never fires
   always_comb
   begin
      case (turbo)
         turbo_1mhz:
            clken_next = (div_cnt[3:0] == 4'd0) & ~div_cnt[4];
         turbo_2mhz:
            clken_next = (div_cnt[2:0] == 3'd0) & ~div_cnt[4];
         default:
            // 4 MHz, counts 0 4 8 12
            clken_next = (div_cnt[1:0] == 2'd0) & ~div_cnt[4];
      endcase
   end

   // Frame counter and registered enable
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         div_cnt   <= 5'd0;
         cpu_clken <= 1'b0;
      end
      else
      begin
         if (div_cnt == 5'(`ATOM_CLKDIV_LAST))
            div_cnt <= 5'd0;
         else
            div_cnt <= div_cnt + 5'd1;
         // One clock behind the count
         cpu_clken <= clken_next;
      end
   end

endmodule

// ==== rtl/pia_8255.sv ====
`timescale 1ns/1ns

module pia_8255
(
   input  logic                   clk25,
   input  logic                   reset,
   input  logic                   cpu_clken,
   input  atom_glue_pkg::addr_t   bus_addr,
   input  atom_glue_pkg::byte_t   bus_wdata,
   input  logic                   bus_rnw,
   input  logic                   pia_sel,
   input  logic [5:0]             key_cols,
   input  logic                   shift_n,
   input  logic                   ctrl_n,
   input  logic                   rept_n,
   input  logic                   cas_in,
   input  logic                   fs_n,
   input  logic                   cas_tone,
   output atom_glue_pkg::byte_t   port_a,
   output atom_glue_pkg::nibble_t port_c_lo,
   output atom_glue_pkg::byte_t   pia_rdata
);

   import atom_glue_pkg::*;

   // Fixed directions, A and C low out, B and C high in
   byte_t port_b;
   byte_t port_c;
   logic  wr_en;

   assign port_b = {shift_n, ctrl_n, key_cols};
   assign port_c = {fs_n, rept_n, cas_in, cas_tone, port_c_lo};

   // Write strobe for this block
   assign wr_en = cpu_clken & pia_sel & ~bus_rnw;

   // ======================================================================
   // Output registers
   // ======================================================================

   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         port_a    <= 8'h00;
         port_c_lo <= 4'h0;
      end
      else if (wr_en)
      begin
         case (bus_addr[1:0])
            2'b00:
               port_a <= bus_wdata;
            2'b10:
               port_c_lo <= bus_wdata[3:0];
            2'b11:
               // Bit set/reset, mode words (bit 7 set) ignored
               if (!bus_wdata[7])
                  port_c_lo[bus_wdata[2:1]] <= bus_wdata[0];
            default:
               ;
         endcase
      end
   end

   // Register read, control word reads as zero
   always_comb
   begin
      case (bus_addr[1:0])
         2'b00:   pia_rdata = port_a;
         2'b01:   pia_rdata = port_b;
         2'b10:   pia_rdata = port_c;
         default: pia_rdata = 8'h00;
      endcase
   end

endmodule
